/* hdl/rowbuf_pkg.sv */
package rowbuf_pkg;

    // Pixel and bank geometry
    localparam int PIXEL_WIDTH     = 16;
    localparam int BANK_DEPTH      = 512;
    localparam int BANK_ADDR_WIDTH = $clog2(BANK_DEPTH);
    localparam int COL_WIDTH       = BANK_ADDR_WIDTH - 1;

    // Sequence word field positions
    localparam int SEQ_ROW_SEL_BIT  = 2 * COL_WIDTH;
    localparam int SEQ_COL_ODD_LSB  = COL_WIDTH;
    localparam int SEQ_COL_EVEN_LSB = 0;

    // Cycles from a sampled execute to valid bank data
    localparam int READ_LATENCY = 2;

    typedef logic [PIXEL_WIDTH-1:0]     pixel_t;
    typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;
    typedef logic [COL_WIDTH-1:0]       col_t;
    typedef logic [2*COL_WIDTH:0]       pix_seq_t;
    typedef logic [1:0]                 gray_t;

    // One-hot layer controller states
    typedef enum logic [4:0] {
        ST_IDLE          = 5'b00001,
        ST_PRIM_BUFFER   = 5'b00010,
        ST_WAIT_PFB_LOAD = 5'b00100,
        ST_ACTIVE        = 5'b01000,
        ST_JOB_DONE      = 5'b10000
    } layer_state_t;

endpackage

/* hdl/row_bank_if.sv */
`timescale 1ns/100ps

interface row_bank_if;
    import rowbuf_pkg::*;

    // Write port, loaded during priming
    logic       wren;
    bank_addr_t wr_addr;
    pixel_t     wr_data;

    // Read port, used while the engine is active
    logic       rden;
    bank_addr_t rd_addr;
    pixel_t     rd_data;

    modport writer (
        output wren,
        output wr_addr,
        output wr_data
    );

    modport reader (
        output rden,
        output rd_addr,
        input  rd_data
    );

    modport ram (
        input  wren, wr_addr, wr_data,
        input  rden, rd_addr,
        output rd_data
    );

endinterface

/* hdl/row_bank_ram.sv */
`timescale 1ns/100ps

module row_bank_ram #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 512
) (
    input logic     clk,
    row_bank_if.ram bank
);

    ////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////

    logic [WIDTH-1:0] mem [DEPTH];

    // Synchronous write port
    always_ff @(posedge clk) begin
        if (bank.wren) begin
            mem[bank.wr_addr] <= bank.wr_data;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Registered read
    ////////////////////////////////////////////////////////////////////

    // No-change output holds the last word until the next read
    always_ff @(posedge clk) begin
        if (bank.rden) begin
            bank.rd_data <= mem[bank.rd_addr];
        end
    end

endmodule

/* hdl/prime_writer.sv */
`timescale 1ns/100ps

module prime_writer (
    input  logic                     clk,
    input  logic                     rst,
    input  rowbuf_pkg::layer_state_t state,
    input  logic                     pfb_rden,
    input  rowbuf_pkg::col_t         input_row,
    input  rowbuf_pkg::col_t         input_col,
    input  rowbuf_pkg::col_t         num_input_cols,
    input  rowbuf_pkg::pixel_t       pixel_datain,
    row_bank_if.writer               bank0,
    row_bank_if.writer               bank1
);
    import rowbuf_pkg::*;

    logic prime_valid;
    logic hit0;
    logic hit1;
    logic half0;
    logic half1;

    ////////////////////////////////////////////////////////////////////
    // Priming decode
    ////////////////////////////////////////////////////////////////////

    assign prime_valid = (state == ST_PRIM_BUFFER) && pfb_rden
                         && (input_col <= num_input_cols);

    // Row 0 fills the lower half of both banks,
    // rows 1 and 2 fill the upper half of one bank each
    always_comb begin
        hit0  = 1'b0;
        hit1  = 1'b0;
        half0 = 1'b0;
        half1 = 1'b0;
        if (prime_valid) begin
            case (input_row)
                col_t'(0): begin
                    hit0 = 1'b1;
                    hit1 = 1'b1;
                end
                col_t'(1): begin
                    hit1  = 1'b1;
                    half1 = 1'b1;
                end
                col_t'(2): begin
                    hit0  = 1'b1;
                    half0 = 1'b1;
                end
                default: begin
                    hit0 = 1'b0;
                    hit1 = 1'b0;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Write registers
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            bank0.wren <= 1'b0;
            bank1.wren <= 1'b0;
        end else begin
            bank0.wren <= hit0;
            bank1.wren <= hit1;
        end
    end

    // Address and pixel only move when a write is issued
    always_ff @(posedge clk) begin
        if (hit0) begin
            bank0.wr_addr <= {half0, input_col};
            bank0.wr_data <= pixel_datain;
        end
        if (hit1) begin
            bank1.wr_addr <= {half1, input_col};
            bank1.wr_data <= pixel_datain;
        end
    end

endmodule

/* hdl/read_sequencer.sv */
`timescale 1ns/100ps

module read_sequencer (
    input  logic                          clk,
    input  logic                          rst,
    input  rowbuf_pkg::layer_state_t      state,
    input  logic                          execute,
    input  rowbuf_pkg::gray_t             gray_code,
    input  rowbuf_pkg::pix_seq_t          pix_seq_datain,
    row_bank_if.reader                    bank0,
    row_bank_if.reader                    bank1,
    output rowbuf_pkg::pixel_t [1:0]      pixel_dataout,
    output logic                          dataout_valid
);
    import rowbuf_pkg::*;

    logic                    rd_req;
    logic                    row_sel;
    col_t                    col_even;
    col_t                    col_odd;
    logic [READ_LATENCY-1:0] valid_pipe;

    ////////////////////////////////////////////////////////////////////
    // Sequence word decode
    ////////////////////////////////////////////////////////////////////

    assign row_sel  = pix_seq_datain[SEQ_ROW_SEL_BIT];
    assign col_odd  = pix_seq_datain[SEQ_COL_ODD_LSB +: COL_WIDTH];
    assign col_even = pix_seq_datain[SEQ_COL_EVEN_LSB +: COL_WIDTH];

    assign rd_req = (state == ST_ACTIVE) && execute;

    ////////////////////////////////////////////////////////////////////
    // Read issue
    ////////////////////////////////////////////////////////////////////

    // Gray code bit per bank flips which row half is current
    always_ff @(posedge clk) begin
        if (rd_req) begin
            bank0.rd_addr <= {gray_code[0] ^ row_sel, col_even};
            bank1.rd_addr <= {gray_code[1] ^ row_sel, col_odd};
        end
    end

    // Stage 0 is the read enable itself, last stage lines up with rd_data
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[READ_LATENCY-2:0], rd_req};
        end
    end

    assign bank0.rden = valid_pipe[0];
    assign bank1.rden = valid_pipe[0];

    ////////////////////////////////////////////////////////////////////
    // Output
    ////////////////////////////////////////////////////////////////////

    assign dataout_valid = valid_pipe[READ_LATENCY-1];
    // Bank 1 in the upper pixel slot
    assign pixel_dataout = {bank1.rd_data, bank0.rd_data};

endmodule

/* hdl/rowbuf_accel.sv */
`timescale 1ns/100ps

module rowbuf_accel (
    input  logic                          clk,
    input  logic                          rst,
    input  rowbuf_pkg::layer_state_t      state,
    input  rowbuf_pkg::gray_t             gray_code,
    input  rowbuf_pkg::col_t              input_row,
    input  rowbuf_pkg::col_t              input_col,
    input  rowbuf_pkg::col_t              num_input_cols,
    input  logic                          pfb_rden,
    input  rowbuf_pkg::pixel_t            pixel_datain,
    input  logic                          execute,
    input  rowbuf_pkg::pix_seq_t          pix_seq_datain,
    output rowbuf_pkg::pixel_t [1:0]      pixel_dataout,
    output logic                          dataout_valid
);
    import rowbuf_pkg::*;

    row_bank_if bank0_if ();
    row_bank_if bank1_if ();

    ////////////////////////////////////////////////////////////////////
    // Pixel banks
    ////////////////////////////////////////////////////////////////////

    row_bank_ram #(
        .WIDTH (PIXEL_WIDTH),
        .DEPTH (BANK_DEPTH)
    ) u_bank0 (
        .clk  (clk),
        .bank (bank0_if)
    );

    row_bank_ram #(
        .WIDTH (PIXEL_WIDTH),
        .DEPTH (BANK_DEPTH)
    ) u_bank1 (
        .clk  (clk),
        .bank (bank1_if)
    );

    ////////////////////////////////////////////////////////////////////
    // Priming and read control
    ////////////////////////////////////////////////////////////////////

    prime_writer u_prime_writer (
        .clk            (clk),
        .rst            (rst),
        .state          (state),
        .pfb_rden       (pfb_rden),
        .input_row      (input_row),
        .input_col      (input_col),
        .num_input_cols (num_input_cols),
        .pixel_datain   (pixel_datain),
        .bank0          (bank0_if),
        .bank1          (bank1_if)
    );

    // Even columns from bank 0, odd columns from bank 1
    read_sequencer u_read_sequencer (
        .clk            (clk),
        .rst            (rst),
        .state          (state),
        .execute        (execute),
        .gray_code      (gray_code),
        .pix_seq_datain (pix_seq_datain),
        .bank0          (bank0_if),
        .bank1          (bank1_if),
        .pixel_dataout  (pixel_dataout),
        .dataout_valid  (dataout_valid)
    );

endmodule

/* tb/rowbuf_accel_tb.sv */
`timescale 1ns/100ps

module rowbuf_accel_tb;
    import rowbuf_pkg::*;

    // One table row is applied for one clock cycle
    typedef struct packed {
        layer_state_t state;
        col_t         row;
        col_t         col;
        col_t         ncols;
        logic         pfb;
        logic         exec_en;
        logic         row_sel;
        col_t         col_even;
        col_t         col_odd;
        gray_t        gray;
    } step_t;

    logic         clk;
    logic         rst;
    layer_state_t state;
    gray_t        gray_code;
    col_t         input_row;
    col_t         input_col;
    col_t         num_input_cols;
    logic         pfb_rden;
    pixel_t       pixel_datain;
    logic         execute;
    pix_seq_t     pix_seq_datain;
    pixel_t [1:0] pixel_dataout;
    logic         dataout_valid;

    step_t        steps[$];
    logic [31:0]  expected_q[$];
    pixel_t       bank0_model [BANK_DEPTH];
    pixel_t       bank1_model [BANK_DEPTH];
    logic [31:0]  rng;
    logic [1:0]   req_hist;
    gray_t        gray_order [4] = '{2'b00, 2'b01, 2'b11, 2'b10};
    int           timeout;

    rowbuf_accel u_dut (
        .clk            (clk),
        .rst            (rst),
        .state          (state),
        .gray_code      (gray_code),
        .input_row      (input_row),
        .input_col      (input_col),
        .num_input_cols (num_input_cols),
        .pfb_rden       (pfb_rden),
        .pixel_datain   (pixel_datain),
        .execute        (execute),
        .pix_seq_datain (pix_seq_datain),
        .pixel_dataout  (pixel_dataout),
        .dataout_valid  (dataout_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at time %0t: %s expected %h got %h", $time, what, expected,
                     actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic add_step(input layer_state_t st, input int row, input int col,
                            input int ncols, input logic pfb, input logic exec_en,
                            input logic row_sel, input int col_even, input int col_odd,
                            input gray_t gray);
        step_t s;
        s.state    = st;
        s.row      = col_t'(row);
        s.col      = col_t'(col);
        s.ncols    = col_t'(ncols);
        s.pfb      = pfb;
        s.exec_en  = exec_en;
        s.row_sel  = row_sel;
        s.col_even = col_t'(col_even);
        s.col_odd  = col_t'(col_odd);
        s.gray     = gray;
        steps.push_back(s);
    endtask

    // Row 0 goes to the low half of both banks, row 1 to the high half of
    // bank 1 and row 2 to the high half of bank 0
    task automatic update_model(input step_t s, input pixel_t pix);
        if ((s.state == ST_PRIM_BUFFER) && s.pfb && (s.col <= s.ncols)) begin
            if (s.row == col_t'(0)) begin
                bank0_model[{1'b0, s.col}] = pix;
                bank1_model[{1'b0, s.col}] = pix;
            end else if (s.row == col_t'(1)) begin
                bank1_model[{1'b1, s.col}] = pix;
            end else if (s.row == col_t'(2)) begin
                bank0_model[{1'b1, s.col}] = pix;
            end
        end
    endtask

    task automatic apply_step(input step_t s);
        pixel_t     pix;
        bank_addr_t addr0;
        bank_addr_t addr1;
        rng = xorshift32(rng);
        pix = rng[PIXEL_WIDTH-1:0];
        state          <= s.state;
        input_row      <= s.row;
        input_col      <= s.col;
        num_input_cols <= s.ncols;
        pfb_rden       <= s.pfb;
        pixel_datain   <= pix;
        execute        <= s.exec_en;
        gray_code      <= s.gray;
        pix_seq_datain <= {s.row_sel, s.col_odd, s.col_even};
        update_model(s, pix);
        // Gray bit per bank XOR row_sel picks the read half
        if ((s.state == ST_ACTIVE) && s.exec_en) begin
            addr0 = {s.gray[0] ^ s.row_sel, s.col_even};
            addr1 = {s.gray[1] ^ s.row_sel, s.col_odd};
            expected_q.push_back({bank1_model[addr1], bank0_model[addr0]});
        end
    endtask

    task automatic build_table();
        // Execute outside ST_ACTIVE must not read
        add_step(ST_IDLE, 0, 0, 3, 1'b0, 1'b1, 1'b0, 0, 0, 2'b00);
        add_step(ST_WAIT_PFB_LOAD, 0, 0, 3, 1'b0, 1'b1, 1'b1, 1, 2, 2'b01);
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c <= 3; c++) begin
                add_step(ST_PRIM_BUFFER, r, c, 3, 1'b1, 1'b1, 1'b0, 0, 0, 2'b00);
            end
        end
        // Writes that must be dropped
        add_step(ST_PRIM_BUFFER, 0, 3, 2, 1'b1, 1'b0, 1'b0, 0, 0, 2'b00);
        add_step(ST_PRIM_BUFFER, 3, 1, 3, 1'b1, 1'b0, 1'b0, 0, 0, 2'b00);
        add_step(ST_PRIM_BUFFER, 1, 0, 3, 1'b0, 1'b0, 1'b0, 0, 0, 2'b00);
        add_step(ST_IDLE, 2, 2, 3, 1'b1, 1'b0, 1'b0, 0, 0, 2'b00);
        add_step(ST_WAIT_PFB_LOAD, 0, 0, 3, 1'b0, 1'b0, 1'b0, 0, 0, 2'b00);
        add_step(ST_WAIT_PFB_LOAD, 0, 0, 3, 1'b0, 1'b0, 1'b0, 0, 0, 2'b00);
        // Back to back reads for every gray code with one gap per code
        for (int g = 0; g < 4; g++) begin
            for (int rs = 0; rs < 2; rs++) begin
                for (int c = 0; c <= 3; c++) begin
                    add_step(ST_ACTIVE, 0, 0, 3, 1'b0, 1'b1, rs[0], c, 3 - c,
                             gray_order[g]);
                end
            end
            add_step(ST_ACTIVE, 0, 0, 3, 1'b0, 1'b0, 1'b0, 0, 0, gray_order[g]);
        end
        add_step(ST_JOB_DONE, 0, 0, 3, 1'b0, 1'b1, 1'b0, 0, 0, 2'b00);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output monitor
    //////////////////////////////////////////////////////////////////////

    // Valid must follow a sampled read by exactly READ_LATENCY cycles
    always @(negedge clk) begin
        if (rst) begin
            req_hist <= '0;
        end else begin
            check_value(32'(dataout_valid), 32'(req_hist[1]), "dataout_valid");
            if (dataout_valid) begin
                if (expected_q.size() == 0) begin
                    $display("Output valid at time %0t with no read outstanding", $time);
                    $display("TEST RESULT: FAIL");
                    $fatal(1, "Unexpected output");
                end
                check_value(pixel_dataout, expected_q.pop_front(), "pixel_dataout");
            end
            req_hist <= {req_hist[0], (state == ST_ACTIVE) && execute};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst            = 1'b1;
        state          = ST_IDLE;
        gray_code      = '0;
        input_row      = '0;
        input_col      = '0;
        num_input_cols = '0;
        pfb_rden       = 1'b0;
        pixel_datain   = '0;
        execute        = 1'b0;
        pix_seq_datain = '0;
        rng            = 32'd50262;
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        foreach (steps[i]) begin
            @(posedge clk);
            apply_step(steps[i]);
        end
        @(posedge clk);
        state   <= ST_IDLE;
        execute <= 1'b0;
        timeout = 0;
        while (expected_q.size() != 0) begin
            @(posedge clk);
            timeout++;
            if (timeout > 10) begin
                $display("Timed out waiting for outstanding reads to return");
                $display("TEST RESULT: FAIL");
                $fatal(1, "Read timeout");
            end
        end
        @(posedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* rowbuf_accel.f */
hdl/rowbuf_pkg.sv
hdl/row_bank_if.sv
hdl/row_bank_ram.sv
hdl/prime_writer.sv
hdl/read_sequencer.sv
hdl/rowbuf_accel.sv
tb/rowbuf_accel_tb.sv

/* Makefile */
TOP := rowbuf_accel_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --timescale 1ns/100ps -f rowbuf_accel.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null

clean:
	rm -rf obj_dir
